//--- design/bus_control.sv
// address decode, LED register, device start strobes and read data mux
// IO reads are combinational; RAM reads come from the RAM one clock after the address
// no back-pressure: the master polls rbusy/wbusy before starting a device
`timescale 1ns/10ps
`default_nettype none

module bus_control (
  input  logic                                 clk,
  input  logic                                 RESET,
  input  soc_bus_pkg::bus_req_t                req,
  output soc_bus_pkg::bus_rsp_t                rsp,
  output logic                                 ram_we,
  output logic [soc_bus_pkg::RAM_AW-1:0]       ram_index,
  output logic [soc_bus_pkg::MASK_W-1:0]       ram_mask,
  output logic [soc_bus_pkg::DATA_W-1:0]       ram_wdata,
  input  logic [soc_bus_pkg::DATA_W-1:0]       ram_rdata,
  output logic                                 start_matrix,
  output logic [soc_io_pkg::MATRIX_BITS-1:0]   matrix_data,
  output logic                                 start_flash,
  output logic [soc_io_pkg::FLASH_ADDR_W-1:0]  flash_addr,
  input  soc_io_pkg::io_status_t               status,
  input  logic [soc_io_pkg::BUTTON_W-1:0]      buttons,
  output logic [soc_io_pkg::LED_W-1:0]         leds
);

  import soc_bus_pkg::*;
  import soc_io_pkg::*;

  logic                io_page;
  logic [IO_SEL_W-1:0] io_sel;
  logic                wr;
  logic                io_wr;
  logic [DATA_W-1:0]   io_rdata;

  assign io_page = req.addr.ram.io;
  assign io_sel  = req.addr.io.io_sel;
  assign wr      = |req.wmask;
  assign io_wr   = wr && io_page;

  // RAM side
  assign ram_we    = wr && !io_page;
  assign ram_index = req.addr.ram.word_addr[RAM_AW-1:0]; // upper word bits ignored
  assign ram_mask  = req.wmask;
  assign ram_wdata = req.wdata;

  // serial engines start on the write strobe itself
  assign start_matrix = io_wr && io_sel[IO_MATRIX_DAT_BIT];
  assign matrix_data  = req.wdata[MATRIX_BITS-1:0];
  assign start_flash  = io_wr && io_sel[IO_FLASH_BIT];
  assign flash_addr   = req.wdata[FLASH_ADDR_W-1:0];

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      leds <= '0;
    end else if (io_wr && io_sel[IO_LEDS_BIT]) begin
      leds <= req.wdata[LED_W-1:0];
    end
  end

  // several select bits may be set, their words are ORed
  always_comb begin
    io_rdata = '0;
    if (io_sel[IO_LEDS_BIT])        io_rdata |= DATA_W'(leds);
    if (io_sel[IO_MATRIX_CNTL_BIT]) io_rdata |= DATA_W'(status.matrix_busy);
    if (io_sel[IO_FLASH_BIT])       io_rdata |= DATA_W'(status.flash_byte);
    if (io_sel[IO_BUTTONS_BIT])     io_rdata |= DATA_W'(buttons);
  end

  always_comb begin
    rsp.rdata = io_page ? io_rdata : ram_rdata;
    rsp.rbusy = status.flash_receiving;
    rsp.wbusy = status.matrix_busy | status.flash_sending;
  end

  // the master never reads and writes in one access
  a_no_rd_wr: assert property (@(posedge clk) disable iff (!RESET) !(wr && req.rd));

endmodule

`default_nettype wire

//--- design/led_matrix_shifter.sv
// 16-bit MSB-first sender for a MAX7219-style matrix, one bit every 8 clocks
// the receiver samples din while sclk is high; a new start restarts the frame
`timescale 1ns/10ps
`default_nettype none

module led_matrix_shifter (
  input  logic                                clk,
  input  logic                                RESET,
  input  logic                                start,
  input  logic [soc_io_pkg::MATRIX_BITS-1:0]  data,
  output logic                                busy,
  output logic                                din,
  output logic                                cs,
  output logic                                sclk
);

  import soc_io_pkg::*;

  logic [MATRIX_BITS-1:0]  shifter;
  logic [MATRIX_CNT_W-1:0] bit_cnt;   // bits left, 0 when idle
  logic [MATRIX_DIV_W-1:0] div;
  logic                    slow_en;

  assign slow_en = (div == '0);
  assign busy    = |bit_cnt;
  assign cs      = !busy;
  assign sclk    = busy && slow_en; // one-clock pulse per bit
  assign din     = shifter[MATRIX_BITS-1];

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      div     <= '0;
      bit_cnt <= '0;
      shifter <= '0;
    end else begin
      div <= div + 1'b1; // free running
      if (start) begin
        shifter <= data;
        bit_cnt <= MATRIX_CNT_W'(MATRIX_BITS);
      end else if (busy && slow_en) begin
        shifter <= {shifter[MATRIX_BITS-2:0], 1'b0};
        bit_cnt <= bit_cnt - 1'b1;
      end
    end
  end

  // once idle, no clock pulse until the next start
  a_sclk_idle: assert property (@(posedge clk) disable iff (!RESET)
    (!busy && !start) |=> !sclk);

endmodule

`default_nettype wire

//--- design/mem_io_subsystem.sv
// memory and IO side of a small RISC-V SoC, driven straight by a data bus
// RESET is asynchronous active low and used directly, no power-on delay
`timescale 1ns/10ps
`default_nettype none

module mem_io_subsystem (
  input  logic                              clk,
  input  logic                              RESET,
  input  soc_bus_pkg::bus_req_t             req,
  output soc_bus_pkg::bus_rsp_t             rsp,
  input  logic [soc_io_pkg::BUTTON_W-1:0]   buttons,
  output logic [soc_io_pkg::LED_W-1:0]      leds,
  output logic                              ledmtx_din,
  output logic                              ledmtx_cs,
  output logic                              ledmtx_clk,
  output logic                              spi_mosi,
  output logic                              spi_cs_n,
  output logic                              spi_clk,
  input  logic                              spi_miso
);

  import soc_bus_pkg::*;
  import soc_io_pkg::*;

  logic                    ram_we;
  logic [RAM_AW-1:0]       ram_index;
  logic [MASK_W-1:0]       ram_mask;
  logic [DATA_W-1:0]       ram_wdata;
  logic [DATA_W-1:0]       ram_rdata;
  logic                    start_matrix;
  logic [MATRIX_BITS-1:0]  matrix_data;
  logic                    start_flash;
  logic [FLASH_ADDR_W-1:0] flash_addr;
  io_status_t              status;     // fields driven by the two engines

  bus_control i_bus_control (
    .clk, .RESET, .req, .rsp,
    .ram_we, .ram_index, .ram_mask, .ram_wdata, .ram_rdata,
    .start_matrix, .matrix_data, .start_flash, .flash_addr,
    .status, .buttons, .leds
  );

  word_ram i_word_ram (
    .clk, .we(ram_we), .index(ram_index), .mask(ram_mask),
    .wdata(ram_wdata), .rdata(ram_rdata)
  );

  led_matrix_shifter i_matrix (
    .clk, .RESET, .start(start_matrix), .data(matrix_data),
    .busy(status.matrix_busy), .din(ledmtx_din), .cs(ledmtx_cs), .sclk(ledmtx_clk)
  );

  spi_flash_reader i_flash (
    .clk, .RESET, .start(start_flash), .addr(flash_addr), .miso(spi_miso),
    .sending(status.flash_sending), .receiving(status.flash_receiving),
    .rx_byte(status.flash_byte), .mosi(spi_mosi), .cs_n(spi_cs_n), .sclk(spi_clk)
  );

endmodule

`default_nettype wire

//--- design/soc_bus_pkg.sv
// processor-side bus definitions: 24-bit byte address, 32-bit data, 4-bit byte mask
// the io view of the address uses soc_io_pkg, so compile soc_io_pkg before this package
`default_nettype none

package soc_bus_pkg;

  localparam int ADDR_W    = 24;
  localparam int DATA_W    = 32;
  localparam int MASK_W    = 4;
  localparam int RAM_WORDS = 1024;
  localparam int RAM_AW    = $clog2(RAM_WORDS); // word address is cut down to this

  // bit 22 picks the page and the rest reads differently per page
  typedef union packed {
    struct packed {
      logic                             spare;
      logic                             io;
      logic [ADDR_W-5:0]                word_addr; // 20 bits
      logic [1:0]                       byte_off;
    } ram;
    struct packed {
      logic                             spare;
      logic                             io;
      logic [ADDR_W-soc_io_pkg::IO_SEL_W-5:0] unused;
      logic [soc_io_pkg::IO_SEL_W-1:0]  io_sel;   // one-hot device select
      logic [1:0]                       byte_off;
    } io;
  } bus_addr_u;

  typedef struct packed {
    bus_addr_u          addr;
    logic [DATA_W-1:0]  wdata;
    logic [MASK_W-1:0]  wmask; // nonzero means write
    logic               rd;
  } bus_req_t;

  typedef struct packed {
    logic [DATA_W-1:0]  rdata;
    logic               rbusy;
    logic               wbusy;
  } bus_rsp_t;

endpackage

`default_nettype wire

//--- design/soc_io_pkg.sv
// IO page layout and serial device constants
// select bits are positions in word-address bits 12:2, one device per bit
`default_nettype none

package soc_io_pkg;

  localparam int IO_SEL_W = 11;

  localparam int IO_LEDS_BIT        = 0;  // r/w, 4 LSBs
  localparam int IO_MATRIX_CNTL_BIT = 6;  // read busy in bit 0
  localparam int IO_MATRIX_DAT_BIT  = 7;  // write 16-bit frame
  localparam int IO_FLASH_BIT       = 8;  // write address, read byte
  localparam int IO_BUTTONS_BIT     = 10; // read only

  localparam int LED_W    = 4;
  localparam int BUTTON_W = 6;

  // led matrix shifter
  localparam int MATRIX_BITS  = 16;
  localparam int MATRIX_DIV_W = 3; // one shift every 2**3 clocks
  localparam int MATRIX_CNT_W = $clog2(MATRIX_BITS) + 1;

  // spi flash reader
  localparam logic [7:0] FLASH_READ_CMD = 8'h03;
  localparam int FLASH_ADDR_W   = 24;
  localparam int FLASH_BYTE_W   = 8;
  localparam int FLASH_TX_BITS  = $bits(FLASH_READ_CMD) + FLASH_ADDR_W;
  localparam int FLASH_TX_CNT_W = $clog2(FLASH_TX_BITS) + 1;
  localparam int FLASH_RX_CNT_W = $clog2(FLASH_BYTE_W) + 1;

  typedef struct packed {
    logic                    matrix_busy;
    logic                    flash_sending;
    logic                    flash_receiving;
    logic [FLASH_BYTE_W-1:0] flash_byte;
  } io_status_t;

endpackage

`default_nettype wire

//--- design/spi_flash_reader.sv
// SPI flash read: sends 03h plus a 24-bit address, then shifts in one byte
// one shift per two clocks; rx_byte holds until the next transfer completes
`timescale 1ns/10ps
`default_nettype none

module spi_flash_reader (
  input  logic                                 clk,
  input  logic                                 RESET,
  input  logic                                 start,
  input  logic [soc_io_pkg::FLASH_ADDR_W-1:0]  addr,
  input  logic                                 miso,
  output logic                                 sending,
  output logic                                 receiving,
  output logic [soc_io_pkg::FLASH_BYTE_W-1:0]  rx_byte,
  output logic                                 mosi,
  output logic                                 cs_n,
  output logic                                 sclk
);

  import soc_io_pkg::*;

  logic [FLASH_TX_BITS-1:0]  cmd_shift;
  logic [FLASH_TX_CNT_W-1:0] snd_cnt;   // command bits left
  logic [FLASH_RX_CNT_W-1:0] rcv_cnt;   // data bits left
  logic                      slow_en;   // toggles every clock
  logic                      busy;

  assign sending   = |snd_cnt;
  assign receiving = |rcv_cnt;
  assign busy      = sending | receiving;
  assign mosi      = sending && cmd_shift[FLASH_TX_BITS-1];
  assign sclk      = busy && slow_en;

  always_ff @(posedge clk or negedge RESET) begin
    if (!RESET) begin
      slow_en   <= 1'b0;
      cs_n      <= 1'b1;
      cmd_shift <= '0;
      snd_cnt   <= '0;
      rcv_cnt   <= '0;
      rx_byte   <= '0;
    end else begin
      slow_en <= ~slow_en;
      if (start) begin
        cs_n      <= 1'b0;
        cmd_shift <= {FLASH_READ_CMD, addr};
        snd_cnt   <= FLASH_TX_CNT_W'(FLASH_TX_BITS);
        rcv_cnt   <= '0; // drop a byte still arriving
      end else begin
        if (sending && slow_en) begin
          if (snd_cnt == FLASH_TX_CNT_W'(1)) begin
            rcv_cnt <= FLASH_RX_CNT_W'(FLASH_BYTE_W); // last address bit, turn around
          end
          snd_cnt   <= snd_cnt - 1'b1;
          cmd_shift <= {cmd_shift[FLASH_TX_BITS-2:0], 1'b0};
        end
        if (receiving && slow_en) begin
          rcv_cnt <= rcv_cnt - 1'b1;
          rx_byte <= {rx_byte[FLASH_BYTE_W-2:0], miso};
        end
        if (!busy && slow_en) begin
          cs_n <= 1'b1;
        end
      end
    end
  end

  // the flash only ever sees clock edges inside a selected frame
  a_sclk_in_frame: assert property (@(posedge clk) disable iff (!RESET)
    (sclk != $past(sclk)) |-> !cs_n);

endmodule

`default_nettype wire

//--- design/word_ram.sv
// single-port word RAM, byte lanes written under mask
// read data is the word at the previous cycle's index; contents undefined until written
`timescale 1ns/10ps
`default_nettype none

module word_ram (
  input  logic                           clk,
  input  logic                           we,
  input  logic [soc_bus_pkg::RAM_AW-1:0] index,
  input  logic [soc_bus_pkg::MASK_W-1:0] mask,
  input  logic [soc_bus_pkg::DATA_W-1:0] wdata,
  output logic [soc_bus_pkg::DATA_W-1:0] rdata
);

  import soc_bus_pkg::*;

  localparam int LANE_W = DATA_W / MASK_W; // 8-bit lanes

  logic [DATA_W-1:0] mem [RAM_WORDS];

  always_ff @(posedge clk) begin
    if (we) begin
      for (int i = 0; i < MASK_W; i++) begin
        if (mask[i]) begin
          mem[index][i*LANE_W +: LANE_W] <= wdata[i*LANE_W +: LANE_W];
        end
      end
    end
    // old word on a same-cycle write
    rdata <= mem[index]; // loads every clock, rd strobe not needed
  end

endmodule

`default_nettype wire

//--- mem_io_subsystem.f
design/soc_io_pkg.sv
design/soc_bus_pkg.sv
design/word_ram.sv
design/bus_control.sv
design/led_matrix_shifter.sv
design/spi_flash_reader.sv
design/mem_io_subsystem.sv
verification/tb_clock_gen.sv
verification/spi_flash_model.sv
verification/mem_io_subsystem_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator; the log decides pass or fail
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Mdir obj_dir \
  --top-module mem_io_subsystem_tb -f mem_io_subsystem.f
./obj_dir/Vmem_io_subsystem_tb | tee sim.log

if grep -qx "Testbench passed" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi

//--- verification/mem_io_subsystem_tb.sv
// testbench for the memory and IO subsystem, stops at the first mismatch
// needs --timing and --assert under Verilator; inputs change 2 ns after the rising edge
`timescale 1ns/10ps
`default_nettype none

module mem_io_subsystem_tb;

  import soc_bus_pkg::*;
  import soc_io_pkg::*;

  typedef enum logic [1:0] {OP_WRITE, OP_READ, OP_BUTTONS, OP_LEDS} op_e;

  typedef struct packed {
    op_e         op;
    logic [23:0] addr;
    logic [3:0]  mask;
    logic [31:0] data;
    logic [31:0] exp_val; // read data or LED value
  } step_t;

  logic                clk;
  logic                RESET;
  bus_req_t            req;
  bus_rsp_t            rsp;
  logic [BUTTON_W-1:0] buttons;
  logic [LED_W-1:0]    leds;
  logic                ledmtx_din;
  logic                ledmtx_cs;
  logic                ledmtx_clk;
  logic                spi_mosi;
  logic                spi_cs_n;
  logic                spi_clk;
  logic                spi_miso;
  logic [7:0]          flash_byte;
  logic [31:0]         cmd_word;
  logic [5:0]          cmd_bits;
  logic [31:0]         rng;
  logic [31:0]         rnd [10];
  step_t               steps [$];

  tb_clock_gen i_clock_gen (.clk, .RESET);

  spi_flash_model i_flash_model (
    .spi_clk, .spi_cs_n, .spi_mosi, .data_byte(flash_byte),
    .spi_miso, .cmd_word, .cmd_bits
  );

  mem_io_subsystem i_dut (
    .clk, .RESET, .req, .rsp, .buttons, .leds,
    .ledmtx_din, .ledmtx_cs, .ledmtx_clk,
    .spi_mosi, .spi_cs_n, .spi_clk, .spi_miso
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                              input logic [31:0] new_w,
                                              input logic [3:0]  mask);
    logic [31:0] w;
    w = old_w;
    for (int i = 0; i < 4; i++) begin
      if (mask[i]) begin
        w[8*i +: 8] = new_w[8*i +: 8];
      end
    end
    return w;
  endfunction

  // io flag plus the one-hot select in word-address bits 12:2
  function automatic logic [23:0] io_addr(input int sel);
    return 24'h400000 | (24'h4 << sel);
  endfunction

  function automatic void add_step(input op_e op, input logic [23:0] addr,
                                   input logic [3:0] mask, input logic [31:0] data,
                                   input logic [31:0] exp_val);
    step_t s;
    s.op      = op;
    s.addr    = addr;
    s.mask    = mask;
    s.data    = data;
    s.exp_val = exp_val;
    steps.push_back(s);
  endfunction

  task automatic stop_with(input string line);
    $display("Testbench failed");
    $display("%s", line);
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] exp_v,
                             input logic [31:0] act);
    assert (act === exp_v) else begin
      stop_with($sformatf("[FAIL] %s expected %h got %h", name, exp_v, act));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic bus_write(input logic [23:0] addr, input logic [3:0] mask,
                           input logic [31:0] data);
    req       = '0;
    req.addr  = addr;
    req.wdata = data;
    req.wmask = mask;
    next_cycle();
    req = '0;
  endtask

  task automatic apply_step(input step_t s);
    case (s.op)
      OP_WRITE: bus_write(s.addr, s.mask, s.data);
      OP_BUTTONS: buttons = s.data[BUTTON_W-1:0];
      OP_LEDS: check_value("leds", s.exp_val, 32'(leds));
      default: begin
        req      = '0;
        req.addr = s.addr;
        req.rd   = 1'b1;
        if (s.addr[22]) begin
          #5; // io words settle in the same cycle
        end else begin
          next_cycle(); // RAM word shows one clock later
        end
        check_value("rsp.rdata", s.exp_val, rsp.rdata);
        if (s.addr[22]) begin
          next_cycle();
        end
        req = '0;
      end
    endcase
  endtask

  task automatic check_reset_state();
    check_value("leds", 32'h0, 32'(leds));
    check_value("ledmtx_cs", 32'h1, 32'(ledmtx_cs));
    check_value("spi_cs_n", 32'h1, 32'(spi_cs_n));
    check_value("ledmtx_clk", 32'h0, 32'(ledmtx_clk));
    check_value("spi_clk", 32'h0, 32'(spi_clk));
    check_value("rsp.rbusy", 32'h0, 32'(rsp.rbusy));
    check_value("rsp.wbusy", 32'h0, 32'(rsp.wbusy));
  endtask

  task automatic run_matrix(input logic [31:0] wdata);
    int          cyc;
    int          nbits;
    logic [15:0] got;
    nbits = 0;
    got   = '0;
    bus_write(io_addr(IO_MATRIX_DAT_BIT), 4'hf, wdata);
    req.addr = io_addr(IO_MATRIX_CNTL_BIT); // poll the control word through the frame
    req.rd   = 1'b1;
    #5; // control word settles before the first look
    for (cyc = 0; nbits < 16; cyc++) begin
      assert (cyc < 160) else stop_with("LED matrix frame did not finish in time");
      check_value("rsp.wbusy", 32'h1, 32'(rsp.wbusy));
      check_value("ledmtx_cs", 32'h0, 32'(ledmtx_cs));
      check_value("rsp.rdata", 32'h1, rsp.rdata);
      if (ledmtx_clk) begin
        got   = {got[14:0], ledmtx_din};
        nbits = nbits + 1;
      end
      next_cycle();
    end
    check_value("rsp.rdata", 32'h0, rsp.rdata);
    check_value("ledmtx_cs", 32'h1, 32'(ledmtx_cs));
    check_value("rsp.wbusy", 32'h0, 32'(rsp.wbusy));
    check_value("ledmtx_din frame", 32'(wdata[15:0]), 32'(got));
    req = '0;
  endtask

  task automatic run_flash(input logic [31:0] wdata);
    int n;
    bus_write(io_addr(IO_FLASH_BIT), 4'hf, wdata);
    for (n = 0; rsp.rbusy !== 1'b1; n++) begin
      assert (n < 100) else stop_with("flash command phase never ended");
      check_value("spi_cs_n", 32'h0, 32'(spi_cs_n));
      check_value("rsp.wbusy", 32'h1, 32'(rsp.wbusy));
      next_cycle();
    end
    for (n = 0; rsp.rbusy === 1'b1; n++) begin
      assert (n < 40) else stop_with("flash data byte never completed");
      next_cycle();
    end
    check_value("flash cmd_word", {8'h03, wdata[23:0]}, cmd_word);
    check_value("flash cmd_bits", 32'd32, 32'(cmd_bits));
    req.addr = io_addr(IO_FLASH_BIT);
    req.rd   = 1'b1;
    #5;
    check_value("rsp.rdata", 32'(flash_byte), rsp.rdata);
    next_cycle();
    req = '0;
    for (n = 0; spi_cs_n !== 1'b1; n++) begin
      assert (n < 4) else stop_with("spi_cs_n stayed low after the transfer");
      next_cycle();
    end
  endtask

  initial begin
    int          n;
    logic [31:0] w1;
    logic [31:0] w2;
    logic [31:0] w3;
    logic [31:0] top_word;
    req     = '0;
    buttons = '0;
    rng     = 32'hfc2e;
    for (int i = 0; i < 10; i++) begin
      rng    = xorshift32(rng);
      rnd[i] = rng;
    end
    flash_byte = rnd[9][7:0];
    for (n = 0; RESET !== 1'b1; n++) begin
      assert (n < 20) else stop_with("RESET was never released");
      next_cycle();
    end
    check_reset_state();

    w1       = rnd[0];
    w2       = merge_bytes(w1, rnd[1], 4'b0011);
    w3       = merge_bytes(w2, rnd[2], 4'b1010);
    top_word = merge_bytes(rnd[4], rnd[5], 4'b0100);
    add_step(OP_WRITE, 24'h000004, 4'b1111, rnd[0], '0);
    add_step(OP_READ, 24'h000004, '0, '0, w1);
    add_step(OP_WRITE, 24'h000004, 4'b0011, rnd[1], '0);
    add_step(OP_READ, 24'h000004, '0, '0, w2);
    add_step(OP_WRITE, 24'h000004, 4'b1010, rnd[2], '0);
    add_step(OP_READ, 24'h000004, '0, '0, w3);
    add_step(OP_WRITE, io_addr(IO_LEDS_BIT), 4'b1111, rnd[3], '0); // same word index 1
    add_step(OP_LEDS, '0, '0, '0, 32'(rnd[3][3:0]));
    add_step(OP_READ, io_addr(IO_LEDS_BIT), '0, '0, 32'(rnd[3][3:0]));
    add_step(OP_READ, 24'h000004, '0, '0, w3);
    add_step(OP_WRITE, 24'h000ffc, 4'b1111, rnd[4], '0);
    add_step(OP_WRITE, 24'h000ffc, 4'b0100, rnd[5], '0);
    add_step(OP_READ, 24'h000ffc, '0, '0, top_word);
    add_step(OP_BUTTONS, '0, '0, rnd[6], '0);
    add_step(OP_READ, io_addr(IO_BUTTONS_BIT), '0, '0, 32'(rnd[6][5:0]));
    add_step(OP_READ, io_addr(IO_MATRIX_CNTL_BIT), '0, '0, 32'h0);
    foreach (steps[i]) begin
      apply_step(steps[i]);
    end

    run_matrix(rnd[7]);
    run_flash(rnd[8]);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- verification/spi_flash_model.sv
// behavioral SPI flash, one read per chip select frame
// samples mosi just after spi_clk rises and answers with data_byte MSB first
`timescale 1ns/10ps
`default_nettype none

module spi_flash_model (
  input  logic        spi_clk,
  input  logic        spi_cs_n,
  input  logic        spi_mosi,
  input  logic [7:0]  data_byte,
  output logic        spi_miso,
  output logic [31:0] cmd_word,  // command and address as received
  output logic [5:0]  cmd_bits
);

  initial begin
    spi_miso = 1'b0;
    cmd_word = '0;
    cmd_bits = '0;
    forever begin
      // the first clock may rise on the same edge that selects the flash
      while (cmd_bits < 6'd32) begin
        @(posedge spi_clk);
        #1;
        if (!spi_cs_n && spi_clk) begin
          cmd_word = {cmd_word[30:0], spi_mosi};
          cmd_bits = cmd_bits + 6'd1;
        end
      end
      // data bits change after each falling clock
      for (int i = 7; i >= 0; i--) begin
        @(negedge spi_clk);
        #1;
        spi_miso = data_byte[i];
      end
      @(posedge spi_cs_n);
      cmd_bits = '0; // next frame counts from zero
    end
  end

endmodule

`default_nettype wire

//--- verification/tb_clock_gen.sv
// 20 ns clock and RESET held low for the first 8 rising edges
// RESET rises 1 ns after the 8th edge, ahead of the 2 ns input drive point
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic RESET
);

  localparam int HALF_PERIOD = 10;

  initial begin
    clk = 1'b0;
    forever #HALF_PERIOD clk = ~clk;
  end

  initial begin
    RESET = 1'b0;
    repeat (8) @(posedge clk);
    #1 RESET = 1'b1;
  end

endmodule

`default_nettype wire
